/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    ////////////////////
    // widths
    localparam int NUM_BANKS = 2;    // bank 0 even lines, bank 1 odd lines
    localparam int FIP_W     = 28;   // 32-bit address minus the byte offset
    localparam int LINE_W    = 128;
    localparam int VPN_W     = 20;
    localparam int PFN_W     = 20;
    localparam int PLINE_W   = 11;   // pfn[2:0] then fip[7:0]
    localparam int TLB_IDX_W = 3;

    typedef logic [FIP_W-1:0]     fip_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [VPN_W-1:0]     vpn_t;
    typedef logic [PFN_W-1:0]     pfn_t;
    typedef logic [PLINE_W-1:0]   pline_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    ////////////////////
    // bank side bundles
    typedef struct packed {
        logic load;    // move the fip to target this cycle
        fip_t target;
    } redirect_t;

    typedef struct packed {
        logic   req;
        pline_t pline;
    } miss_req_t;

    typedef struct packed {
        logic   wr;
        pline_t pline;
        line_t  data;
    } fill_t;

    typedef struct packed {
        logic     wr;      // write strobe
        tlb_idx_t idx;
        vpn_t     vpn;
        pfn_t     pfn;
        logic     valid;
    } tlb_wr_t;

    // refill arbiter fsm
    typedef enum logic {
        ARB_IDLE,
        ARB_WAIT
    } arb_state_t;

endpackage

`default_nettype wire

/* fetch_cf_select.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_cf_select (
    input  wire                    init_i,
    input  wire [31:0]             init_addr_i,
    input  wire                    resteer_i,
    input  wire fetch_pkg::fip_t   wb_fip_even_i,
    input  wire fetch_pkg::fip_t   wb_fip_odd_i,
    input  wire                    bp_taken_i,
    input  wire fetch_pkg::fip_t   bp_fip_even_i,
    input  wire fetch_pkg::fip_t   bp_fip_odd_i,
    output fetch_pkg::redirect_t [fetch_pkg::NUM_BANKS-1:0] redirect_o
);
    import fetch_pkg::*;

    fip_t                 init_line;
    fip_t                 init_line_p1;
    fip_t [NUM_BANKS-1:0] init_fip;
    fip_t [NUM_BANKS-1:0] wb_fip;
    fip_t [NUM_BANKS-1:0] bp_fip;
    logic                 any_cf;

    ////////////////////
    // init address split
    assign init_line    = init_addr_i[31:4];
    assign init_line_p1 = init_line + fip_t'(1);   // next 16-byte line

    // addr bit 4 tells which bank owns the starting line
    assign init_fip[0] = init_line[0] ? init_line_p1 : init_line;
    assign init_fip[1] = init_line[0] ? init_line : init_line_p1;

    assign wb_fip[0] = wb_fip_even_i;
    assign wb_fip[1] = wb_fip_odd_i;
    assign bp_fip[0] = bp_fip_even_i;
    assign bp_fip[1] = bp_fip_odd_i;

    assign any_cf = init_i | resteer_i | bp_taken_i;

    ////////////////////
    // priority init > resteer > branch
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            redirect_o[b].load = any_cf;   // a redirect always loads both banks
            if (init_i) begin
                redirect_o[b].target = init_fip[b];
            end else if (resteer_i) begin
                redirect_o[b].target = wb_fip[b];
            end else begin
                redirect_o[b].target = bp_fip[b];
            end
        end
    end

endmodule

`default_nettype wire

/* itlb.sv */
`timescale 1ns/1ps
`default_nettype none

module itlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  wire                      clk,
    input  wire                      reset_i,
    input  wire fetch_pkg::tlb_wr_t  tlb_wr_i,
    input  wire fetch_pkg::vpn_t     vpn_i,
    output fetch_pkg::pfn_t          pfn_o,
    output logic                     miss_o
);
    import fetch_pkg::*;

    vpn_t                   vpn_tab [TLB_ENTRIES];
    pfn_t                   pfn_tab [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    logic                   found;
    logic                   wr_ok;

    // index beyond the table is dropped
    assign wr_ok = tlb_wr_i.wr && (int'(tlb_wr_i.idx) < TLB_ENTRIES);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_ok) begin
            valid_q[tlb_wr_i.idx] <= tlb_wr_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            vpn_tab[tlb_wr_i.idx] <= tlb_wr_i.vpn;
            pfn_tab[tlb_wr_i.idx] <= tlb_wr_i.pfn;
        end
    end

    ////////////////////
    // lookup, lowest matching entry wins
    always_comb begin
        found = 1'b0;
        pfn_o = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!found && valid_q[i] && (vpn_tab[i] == vpn_i)) begin
                found = 1'b1;
                pfn_o = pfn_tab[i];
            end
        end
    end

    assign miss_o = ~found;

endmodule

`default_nettype wire

/* icache_array.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_array #(
    parameter int SETS = 8
) (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire fetch_pkg::pline_t  pline_i,
    input  wire fetch_pkg::fill_t   fill_i,
    output fetch_pkg::line_t        line_o,
    output logic                    hit_o
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = PLINE_W - 1 - IDX_W;   // bit 0 is bank parity

    line_t             data_mem [SETS];
    logic [TAG_W-1:0]  tag_mem  [SETS];
    logic [SETS-1:0]   valid_q;

    logic [IDX_W-1:0]  rd_idx;
    logic [TAG_W-1:0]  rd_tag;
    logic [IDX_W-1:0]  wr_idx;
    logic [TAG_W-1:0]  wr_tag;

    assign rd_idx = pline_i[IDX_W:1];
    assign rd_tag = pline_i[PLINE_W-1:IDX_W+1];
    assign wr_idx = fill_i.pline[IDX_W:1];
    assign wr_tag = fill_i.pline[PLINE_W-1:IDX_W+1];

    ////////////////////
    // refill writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (fill_i.wr) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i.wr) begin
            data_mem[wr_idx] <= fill_i.data;
            tag_mem[wr_idx]  <= wr_tag;
        end
    end

    // async read
    assign line_o = data_mem[rd_idx];
    assign hit_o  = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

endmodule

`default_nettype wire

/* fetch_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_bank #(
    parameter int SETS        = 8,
    parameter int TLB_ENTRIES = 8
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire fetch_pkg::redirect_t  redirect_i,
    input  wire                        consume_i,
    input  wire fetch_pkg::tlb_wr_t    tlb_wr_i,
    input  wire fetch_pkg::fill_t      fill_i,
    output fetch_pkg::fip_t            fip_o,
    output fetch_pkg::line_t           line_o,
    output logic                       hit_o,
    output logic                       tlb_miss_o,
    output fetch_pkg::miss_req_t       miss_req_o
);
    import fetch_pkg::*;

    fip_t   fip_q;
    pfn_t   pfn;
    pline_t pline;
    logic   cache_hit;

    ////////////////////
    // fip register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_q <= '0;
        end else if (redirect_i.load) begin
            fip_q <= redirect_i.target;
        end else if (consume_i && hit_o) begin
            fip_q <= fip_q + fip_t'(2);   // skip the other bank's line
        end
    end

    assign fip_o = fip_q;

    itlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) itlb_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .tlb_wr_i (tlb_wr_i),
        .vpn_i    (fip_q[27:8]),
        .pfn_o    (pfn),
        .miss_o   (tlb_miss_o)
    );

    // physical line from frame low bits and page offset
    assign pline = {pfn[2:0], fip_q[7:0]};

    icache_array #(
        .SETS (SETS)
    ) icache_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .pline_i (pline),
        .fill_i  (fill_i),
        .line_o  (line_o),
        .hit_o   (cache_hit)
    );

    assign hit_o            = cache_hit & ~tlb_miss_o;
    assign miss_req_o.req   = ~tlb_miss_o & ~cache_hit;   // no refill on a tlb miss
    assign miss_req_o.pline = pline;

endmodule

`default_nettype wire

/* refill_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_arbiter (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire fetch_pkg::miss_req_t [fetch_pkg::NUM_BANKS-1:0] miss_req_i,
    output logic                       refill_req_o,
    output fetch_pkg::pline_t          refill_addr_o,
    input  wire                        refill_valid_i,
    input  wire fetch_pkg::line_t      refill_data_i,
    output fetch_pkg::fill_t [fetch_pkg::NUM_BANKS-1:0] fill_o
);
    import fetch_pkg::*;

    arb_state_t state_q;
    logic       owner_q;   // bank in service, also the last one served
    pline_t     addr_q;
    logic       any_req;
    logic       pick;
    logic       accept;

    assign any_req = miss_req_i[0].req | miss_req_i[1].req;
    assign accept  = (state_q == ARB_IDLE) && any_req;

    // round robin on a tie
    always_comb begin
        if (miss_req_i[0].req && miss_req_i[1].req) begin
            pick = ~owner_q;
        end else begin
            pick = miss_req_i[1].req;
        end
    end

    ////////////////////
    // fsm
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
            owner_q <= 1'b1;   // bank 0 goes first on the first tie
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        state_q <= ARB_WAIT;
                        owner_q <= pick;
                    end
                end
                ARB_WAIT: begin
                    if (refill_valid_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= miss_req_i[pick].pline;
        end
    end

    assign refill_req_o  = (state_q == ARB_WAIT);
    assign refill_addr_o = addr_q;   // held until the data returns

    // return goes to the owner whatever its fip is now
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            fill_o[b].wr    = refill_req_o && refill_valid_i && (owner_q == 1'(b));
            fill_o[b].pline = addr_q;
            fill_o[b].data  = refill_data_i;
        end
    end

endmodule

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int SETS        = 8,
    parameter int TLB_ENTRIES = 8
) (
    input  wire                      clk,
    input  wire                      reset_i,
    // control flow
    input  wire                      init_i,
    input  wire [31:0]               init_addr_i,
    input  wire                      resteer_i,
    input  wire fetch_pkg::fip_t     wb_fip_even_i,
    input  wire fetch_pkg::fip_t     wb_fip_odd_i,
    input  wire                      bp_taken_i,
    input  wire fetch_pkg::fip_t     bp_fip_even_i,
    input  wire fetch_pkg::fip_t     bp_fip_odd_i,
    // decoder took the line
    input  wire                      consume_even_i,
    input  wire                      consume_odd_i,
    // tlb fill
    input  wire                      tlb_wr_i,
    input  wire fetch_pkg::tlb_idx_t tlb_wr_idx_i,
    input  wire fetch_pkg::vpn_t     tlb_wr_vpn_i,
    input  wire fetch_pkg::pfn_t     tlb_wr_pfn_i,
    input  wire                      tlb_wr_valid_i,
    // memory return
    input  wire                      refill_valid_i,
    input  wire fetch_pkg::line_t    refill_data_i,
    // per bank results
    output fetch_pkg::fip_t          fip_even_o,
    output fetch_pkg::fip_t          fip_odd_o,
    output fetch_pkg::line_t         line_even_o,
    output fetch_pkg::line_t         line_odd_o,
    output logic                     hit_even_o,
    output logic                     hit_odd_o,
    output logic                     tlb_miss_even_o,
    output logic                     tlb_miss_odd_o,
    output logic                     refill_req_o,
    output fetch_pkg::pline_t        refill_addr_o
);
    import fetch_pkg::*;

    redirect_t [NUM_BANKS-1:0] redirect_w;
    miss_req_t [NUM_BANKS-1:0] miss_req_w;
    fill_t     [NUM_BANKS-1:0] fill_w;
    fip_t      [NUM_BANKS-1:0] fip_w;
    line_t     [NUM_BANKS-1:0] line_w;
    logic      [NUM_BANKS-1:0] hit_w;
    logic      [NUM_BANKS-1:0] tlb_miss_w;
    logic      [NUM_BANKS-1:0] consume_w;
    tlb_wr_t                   tlb_wr_w;

    assign consume_w = {consume_odd_i, consume_even_i};

    assign tlb_wr_w.wr    = tlb_wr_i;
    assign tlb_wr_w.idx   = tlb_wr_idx_i;
    assign tlb_wr_w.vpn   = tlb_wr_vpn_i;
    assign tlb_wr_w.pfn   = tlb_wr_pfn_i;
    assign tlb_wr_w.valid = tlb_wr_valid_i;

    fetch_cf_select cf_select_inst (
        .init_i        (init_i),
        .init_addr_i   (init_addr_i),
        .resteer_i     (resteer_i),
        .wb_fip_even_i (wb_fip_even_i),
        .wb_fip_odd_i  (wb_fip_odd_i),
        .bp_taken_i    (bp_taken_i),
        .bp_fip_even_i (bp_fip_even_i),
        .bp_fip_odd_i  (bp_fip_odd_i),
        .redirect_o    (redirect_w)
    );

    ////////////////////
    // even and odd banks
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        fetch_bank #(
            .SETS        (SETS),
            .TLB_ENTRIES (TLB_ENTRIES)
        ) bank_inst (
            .clk        (clk),
            .reset_i    (reset_i),
            .redirect_i (redirect_w[b]),
            .consume_i  (consume_w[b]),
            .tlb_wr_i   (tlb_wr_w),   // both banks see the same table
            .fill_i     (fill_w[b]),
            .fip_o      (fip_w[b]),
            .line_o     (line_w[b]),
            .hit_o      (hit_w[b]),
            .tlb_miss_o (tlb_miss_w[b]),
            .miss_req_o (miss_req_w[b])
        );
    end

    refill_arbiter arbiter_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .miss_req_i     (miss_req_w),
        .refill_req_o   (refill_req_o),
        .refill_addr_o  (refill_addr_o),
        .refill_valid_i (refill_valid_i),
        .refill_data_i  (refill_data_i),
        .fill_o         (fill_w)
    );

    assign fip_even_o      = fip_w[0];
    assign fip_odd_o       = fip_w[1];
    assign line_even_o     = line_w[0];
    assign line_odd_o      = line_w[1];
    assign hit_even_o      = hit_w[0];
    assign hit_odd_o       = hit_w[1];
    assign tlb_miss_even_o = tlb_miss_w[0];
    assign tlb_miss_odd_o  = tlb_miss_w[1];

endmodule

`default_nettype wire

/* fetch_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_asserts (
    input wire                    clk,
    input wire                    reset_i,
    input wire                    refill_req_i,
    input wire fetch_pkg::pline_t refill_addr_i,
    input wire                    refill_valid_i,
    input wire                    hit_even_i,
    input wire                    hit_odd_i,
    input wire                    tlb_miss_even_i,
    input wire                    tlb_miss_odd_i
);
    import fetch_pkg::*;

    // request held steady until memory answers
    refill_stable: assert property (@(posedge clk) disable iff (reset_i)
        (refill_req_i && !refill_valid_i) |=> (refill_req_i && $stable(refill_addr_i)))
        else $error("refill request or address changed before refill_valid");

    even_hit_vs_miss: assert property (@(posedge clk) disable iff (reset_i)
        !(hit_even_i && tlb_miss_even_i))
        else $error("even bank shows hit with a tlb miss");

    odd_hit_vs_miss: assert property (@(posedge clk) disable iff (reset_i)
        !(hit_odd_i && tlb_miss_odd_i))
        else $error("odd bank shows hit with a tlb miss");

    quiet_in_reset: assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> !refill_req_i)   // first edge clears the fsm
        else $error("refill request raised during reset");

endmodule

bind fetch_top fetch_asserts fetch_asserts_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .refill_req_i    (refill_req_o),
    .refill_addr_i   (refill_addr_o),
    .refill_valid_i  (refill_valid_i),
    .hit_even_i      (hit_even_o),
    .hit_odd_i       (hit_odd_o),
    .tlb_miss_even_i (tlb_miss_even_o),
    .tlb_miss_odd_i  (tlb_miss_odd_o)
);

`default_nettype wire

/* tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;
    import fetch_pkg::*;

    localparam int SETS         = 8;
    localparam int TLB_ENTRIES  = 8;
    localparam int RESET_CYCLES = 3;
    localparam int SETUP_CYCLES = TLB_ENTRIES;   // one tlb write per cycle
    localparam int RUN_CYCLES   = 3000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + SETUP_CYCLES + RUN_CYCLES;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * 8;
    localparam line_t MEM_PATTERN = 128'h5a3c_96e1_0f7b_c248_d1e6_2a9f_7034_b85d;

    logic clk;
    logic reset_i;
    logic init_i, resteer_i, bp_taken_i;
    logic [31:0] init_addr_i;
    fip_t wb_fip_even_i, wb_fip_odd_i, bp_fip_even_i, bp_fip_odd_i;
    logic consume_even_i, consume_odd_i;
    logic tlb_wr_i, tlb_wr_valid_i;
    tlb_idx_t tlb_wr_idx_i;
    vpn_t tlb_wr_vpn_i;
    pfn_t tlb_wr_pfn_i;
    logic refill_valid_i;
    line_t refill_data_i;
    fip_t fip_even_o, fip_odd_o;
    line_t line_even_o, line_odd_o;
    logic hit_even_o, hit_odd_o, tlb_miss_even_o, tlb_miss_odd_o;
    logic refill_req_o;
    pline_t refill_addr_o;

    // reference model state
    fip_t   m_fip    [NUM_BANKS];
    vpn_t   m_vpn    [TLB_ENTRIES];
    pfn_t   m_pfn    [TLB_ENTRIES];
    logic   m_tvalid [TLB_ENTRIES];
    pline_t m_cline  [NUM_BANKS][SETS];
    logic   m_cvalid [NUM_BANKS][SETS];
    logic   m_arb_wait;
    int     m_owner;
    int     m_last;
    pline_t m_addr;
    logic   m_tmiss  [NUM_BANKS];   // lookup results of the current cycle
    logic   m_hit    [NUM_BANKS];
    pline_t m_pline  [NUM_BANKS];

    integer seed = 32'h9eb1;
    int value_errors = 0;
    int other_errors = 0;
    int refills = 0;
    int dual_misses = 0;
    int tlb_misses_seen = 0;
    int wait_cnt = 0;
    logic resp_busy = 1'b0;

    fetch_top #(
        .SETS        (SETS),
        .TLB_ENTRIES (TLB_ENTRIES)
    ) fetch_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // line the memory returns for a physical line address
    function automatic line_t mem_line(input pline_t p);
        line_t l;
        for (int i = 0; i < LINE_W; i++) begin
            l[i] = p[i % PLINE_W];
        end
        return l ^ MEM_PATTERN;
    endfunction

    function automatic vpn_t rand_vpn();
        return vpn_t'(($random(seed) & 15) % 12);   // 12 pages, tlb holds 8 at most
    endfunction

    function automatic fip_t rand_fip(input logic parity);
        fip_t f;
        f = fip_t'($random(seed));
        f[27:8] = rand_vpn();
        f[0] = parity;
        return f;
    endfunction

    // bank 0 takes the start line when addr bit 4 is 0, bank 1 when it is 1
    function automatic fip_t init_target(input int b, input logic [31:0] addr);
        fip_t l;
        l = addr[31:4];
        if ((addr[4] == 1'b0) == (b == 0)) begin
            return l;
        end
        return l + fip_t'(1);
    endfunction

    function automatic int set_of(input pline_t p);
        return int'(p[PLINE_W-1:1]) % SETS;
    endfunction

    task automatic model_reset();
        for (int b = 0; b < NUM_BANKS; b++) begin
            m_fip[b] = '0;
            for (int s = 0; s < SETS; s++) m_cvalid[b][s] = 1'b0;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) m_tvalid[i] = 1'b0;
        m_arb_wait = 1'b0;
        m_last = 1;   // nothing served yet, bank 0 wins the first tie
    endtask

    task automatic compute_lookup();
        pfn_t pfn;
        logic found;
        int s;
        for (int b = 0; b < NUM_BANKS; b++) begin
            found = 1'b0;
            pfn = '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (!found && m_tvalid[i] && m_vpn[i] == m_fip[b][27:8]) begin
                    found = 1'b1;
                    pfn = m_pfn[i];
                end
            end
            m_tmiss[b] = !found;
            m_pline[b] = {pfn[2:0], m_fip[b][7:0]};
            s = set_of(m_pline[b]);
            m_hit[b] = found && m_cvalid[b][s]
                       && m_cline[b][s][PLINE_W-1:1] == m_pline[b][PLINE_W-1:1];
        end
    endtask

    // advance the model across one rising edge
    task automatic step_model();
        logic consume [NUM_BANKS];
        logic req [NUM_BANKS];
        consume[0] = consume_even_i;
        consume[1] = consume_odd_i;
        for (int b = 0; b < NUM_BANKS; b++) begin
            req[b] = !m_tmiss[b] && !m_hit[b];
            if (init_i) m_fip[b] = init_target(b, init_addr_i);
            else if (resteer_i) m_fip[b] = (b == 0) ? wb_fip_even_i : wb_fip_odd_i;
            else if (bp_taken_i) m_fip[b] = (b == 0) ? bp_fip_even_i : bp_fip_odd_i;
            else if (consume[b] && m_hit[b]) m_fip[b] = m_fip[b] + fip_t'(2);
        end
        if (!m_arb_wait) begin
            if (req[0] || req[1]) begin
                if (req[0] && req[1]) begin
                    m_owner = 1 - m_last;
                    dual_misses++;
                end else begin
                    m_owner = req[1] ? 1 : 0;
                end
                m_last = m_owner;
                m_addr = m_pline[m_owner];
                m_arb_wait = 1'b1;
            end
        end else if (refill_valid_i) begin
            m_cline[m_owner][set_of(m_addr)]  = m_addr;
            m_cvalid[m_owner][set_of(m_addr)] = 1'b1;
            m_arb_wait = 1'b0;
            refills++;
        end
        if (tlb_wr_i) begin
            m_vpn[tlb_wr_idx_i]    = tlb_wr_vpn_i;
            m_pfn[tlb_wr_idx_i]    = tlb_wr_pfn_i;
            m_tvalid[tlb_wr_idx_i] = tlb_wr_valid_i;
        end
    endtask

    // memory side, answers 1 to 6 cycles after the request
    task automatic respond_memory();
        if (refill_valid_i) begin
            refill_valid_i = 1'b0;
        end else if (refill_req_o) begin
            if (!resp_busy) begin
                resp_busy = 1'b1;
                wait_cnt = 1 + (($random(seed) & 32'h7fff_ffff) % 6);
            end
            wait_cnt--;
            if (wait_cnt == 0) begin
                refill_valid_i = 1'b1;
                refill_data_i = mem_line(refill_addr_o);
                resp_busy = 1'b0;
            end
        end
    endtask

    task automatic drive_inputs(input int cyc);
        init_i = 1'b0;
        resteer_i = 1'b0;
        bp_taken_i = 1'b0;
        consume_even_i = 1'b0;
        consume_odd_i = 1'b0;
        tlb_wr_i = 1'b0;
        if (cyc < SETUP_CYCLES) begin
            tlb_wr_i = 1'b1;
            tlb_wr_idx_i = tlb_idx_t'(cyc);
            tlb_wr_vpn_i = rand_vpn();
            tlb_wr_pfn_i = pfn_t'($random(seed));
            tlb_wr_valid_i = 1'b1;
        end else begin
            init_i = (($random(seed) & 31) == 0);
            init_addr_i = $random(seed);
            init_addr_i[31:12] = rand_vpn();
            resteer_i = (($random(seed) & 15) == 0);
            wb_fip_even_i = rand_fip(1'b0);
            wb_fip_odd_i = rand_fip(1'b1);
            bp_taken_i = (($random(seed) & 7) == 0);
            bp_fip_even_i = rand_fip(1'b0);
            bp_fip_odd_i = rand_fip(1'b1);
            consume_even_i = 1'($random(seed));
            consume_odd_i = 1'($random(seed));
            if (($random(seed) & 63) == 0) begin   // occasional remap or unmap
                tlb_wr_i = 1'b1;
                tlb_wr_idx_i = tlb_idx_t'($random(seed));
                tlb_wr_vpn_i = rand_vpn();
                tlb_wr_pfn_i = pfn_t'($random(seed));
                tlb_wr_valid_i = (($random(seed) & 3) != 0);
            end
        end
        respond_memory();
    endtask

    task automatic check_field(input string name, input line_t got, input line_t exp);
        assert (got === exp) else begin
            value_errors++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_outputs();
        compute_lookup();
        check_field("fip_even_o", line_t'(fip_even_o), line_t'(m_fip[0]));
        check_field("fip_odd_o", line_t'(fip_odd_o), line_t'(m_fip[1]));
        check_field("tlb_miss_even_o", line_t'(tlb_miss_even_o), line_t'(m_tmiss[0]));
        check_field("tlb_miss_odd_o", line_t'(tlb_miss_odd_o), line_t'(m_tmiss[1]));
        check_field("hit_even_o", line_t'(hit_even_o), line_t'(m_hit[0]));
        check_field("hit_odd_o", line_t'(hit_odd_o), line_t'(m_hit[1]));
        check_field("refill_req_o", line_t'(refill_req_o), line_t'(m_arb_wait));
        if (m_arb_wait) check_field("refill_addr_o", line_t'(refill_addr_o), line_t'(m_addr));
        if (m_hit[0]) check_field("line_even_o", line_even_o, mem_line(m_pline[0]));
        if (m_hit[1]) check_field("line_odd_o", line_odd_o, mem_line(m_pline[1]));
    endtask

    ////////////////////
    // main sequence
    initial begin
        reset_i = 1'b1;
        init_i = 1'b0;
        init_addr_i = '0;
        resteer_i = 1'b0;
        wb_fip_even_i = '0;
        wb_fip_odd_i = '0;
        bp_taken_i = 1'b0;
        bp_fip_even_i = '0;
        bp_fip_odd_i = '0;
        consume_even_i = 1'b0;
        consume_odd_i = 1'b0;
        tlb_wr_i = 1'b0;
        tlb_wr_idx_i = '0;
        tlb_wr_vpn_i = '0;
        tlb_wr_pfn_i = '0;
        tlb_wr_valid_i = 1'b0;
        refill_valid_i = 1'b0;
        refill_data_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;
        model_reset();
        for (int cyc = 0; cyc < SETUP_CYCLES + RUN_CYCLES; cyc++) begin
            drive_inputs(cyc);
            #3;   // mid cycle, outputs settled
            check_outputs();
            if (cyc >= SETUP_CYCLES && (m_tmiss[0] || m_tmiss[1])) begin
                tlb_misses_seen++;   // unmapped page with the table loaded
            end
            @(posedge clk);
            #1;
            step_model();
        end
        assert (refills > 0) else begin
            other_errors++;
            $display("no refill was ever served");
        end
        assert (dual_misses > 0) else begin
            other_errors++;
            $display("both banks never requested a refill in the same cycle");
        end
        assert (tlb_misses_seen > 0) else begin
            other_errors++;
            $display("no TLB miss was seen on an unmapped page");
        end
        $display("errors: %0d value mismatches, %0d other failures (%0d refills)",
                 value_errors, other_errors, refills);
        if (value_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
fetch_pkg.sv
fetch_cf_select.sv
itlb.sv
icache_array.sv
fetch_bank.sv
refill_arbiter.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fetch -f compile.f -o sim_fetch \
    > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_fetch > sim.log 2>&1
cat sim.log
! grep -q "TESTBENCH FAILED" sim.log && grep -q "TESTBENCH PASSED" sim.log \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
